//--- uart_pkg.sv
// Serial-link types shared by the 8N1 receiver and transmitter; bytes are always 8 bits wide.
package uart_pkg;

	typedef logic [7:0] data_t; // one byte on the serial line.

	// bit phase of a serial frame, used by both directions of the link.
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // line idle high, waiting for work.
		ST_START = 2'd1, // start bit, always low.
		ST_DATA  = 2'd2, // eight data bits, least significant first.
		ST_STOP  = 2'd3 // stop bit, always high.
	} uart_state_e;

endpackage

//--- cmd_pkg.sv
// Frame and command codes of the coprocessor protocol; the result width must be a multiple of 8.
package cmd_pkg;

	localparam uart_pkg::data_t START_CMD = 8'hFE; // opens a frame.
	localparam uart_pkg::data_t END_CMD = 8'hEF; // closes a frame, also inside the payload.

	localparam uart_pkg::data_t CMD1 = 8'h01; // set the vector length from the last payload byte.
	localparam uart_pkg::data_t CMD2 = 8'h02; // start the dot product at the end byte.
	localparam uart_pkg::data_t CMD3 = 8'h03; // clear both operand queues at the end byte.
	localparam uart_pkg::data_t CMD4 = 8'h04; // push each payload byte into queue A.
	localparam uart_pkg::data_t CMD5 = 8'h05; // push each payload byte into queue B.

	// the parser either waits for a byte or spends one cycle handling it.
	typedef enum logic {
		WAIT4BYTE   = 1'b0,
		CHECKSTATUS = 1'b1
	} CMD_STATE_e;

	// position inside the frame grammar.
	typedef enum logic [2:0] {
		IDLECMD = 3'd0, // outside any frame.
		LENGTH  = 3'd1, // start byte seen, length byte expected.
		COMMAND = 3'd2, // command byte expected.
		RCMD1   = 3'd3,
		RCMD2   = 3'd4,
		RCMD3   = 3'd5,
		RCMD4   = 3'd6,
		RCMD5   = 3'd7
	} CMD_STATUS_e;

	localparam int RESULT_W = 24; // accumulator width, sent as three bytes.

endpackage

//--- uart_rx.sv
// 8N1 receiver for an idle-high line; the stop bit is not checked and an unread byte is overwritten.
module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            rx,
	input  logic            clear_interrupt,
	output uart_pkg::data_t uart_data,
	output logic            rx_interrupt
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF = CLKS_PER_BIT / 2;

	uart_pkg::uart_state_e state;
	uart_pkg::data_t shift;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic rx_meta;
	logic rx_sync;
	logic bit_end;
	logic byte_done;

	assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1)); // next sample point is one bit later.
	assign byte_done = (state == uart_pkg::ST_STOP) && bit_end; // middle of the stop bit.

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx; // two flops against metastability.
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state <= uart_pkg::ST_IDLE;
			cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				uart_pkg::ST_IDLE: begin
					cnt <= '0;
					bit_idx <= '0;
					if (!rx_sync)
						state <= uart_pkg::ST_START; // falling edge marks a start bit.
				end
				uart_pkg::ST_START: begin
					if (cnt == CNT_W'(HALF - 1)) begin
						cnt <= '0;
						// a glitch that is high again at mid-bit is not a start bit.
						state <= rx_sync ? uart_pkg::ST_IDLE : uart_pkg::ST_DATA;
					end else
						cnt <= cnt + 1'b1;
				end
				uart_pkg::ST_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_pkg::ST_STOP;
					end else
						cnt <= cnt + 1'b1;
				end
				default: begin
					if (bit_end)
						state <= uart_pkg::ST_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::ST_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]}; // lsb arrives first.
		if (byte_done)
			uart_data <= shift;
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst)
			rx_interrupt <= 1'b0;
		else if (byte_done)
			rx_interrupt <= 1'b1; // a new byte wins over a clear in the same cycle.
		else if (clear_interrupt)
			rx_interrupt <= 1'b0;
	end

endmodule

//--- uart_tx.sv
// 8N1 transmitter; a load is taken only while tx_busy is low, otherwise it is ignored.
module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            tx_load,
	input  uart_pkg::data_t tx_data,
	output logic            tx,
	output logic            tx_busy
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	uart_pkg::uart_state_e state;
	uart_pkg::data_t shift;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic bit_end;

	assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign tx_busy = (state != uart_pkg::ST_IDLE); // rises the cycle after the load.

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state <= uart_pkg::ST_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else begin
			if (state != uart_pkg::ST_IDLE)
				cnt <= bit_end ? '0 : cnt + 1'b1;
			case (state)
				uart_pkg::ST_IDLE: begin
					cnt <= '0;
					bit_idx <= '0;
					if (tx_load) begin
						tx <= 1'b0; // start bit.
						state <= uart_pkg::ST_START;
					end
				end
				uart_pkg::ST_START: begin
					if (bit_end) begin
						tx <= shift[0];
						state <= uart_pkg::ST_DATA;
					end
				end
				uart_pkg::ST_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							tx <= 1'b1; // stop bit.
							state <= uart_pkg::ST_STOP;
						end else
							tx <= shift[1]; // shift[0] has just been sent.
					end
				end
				default: begin
					if (bit_end)
						state <= uart_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::ST_IDLE && tx_load)
			shift <= tx_data;
		else if (state == uart_pkg::ST_DATA && bit_end)
			shift <= shift >> 1;
	end

endmodule

//--- cmd_fsm.sv
// Frame parser: start, ignored length, command, payload, end; unknown commands drop back to idle.
module cmd_fsm (
	input  logic            clk,
	input  logic            rst,
	input  uart_pkg::data_t uart_data,
	input  logic            rx_interrupt,
	output logic            clear_interrupt,
	output logic            push_a,
	output logic            push_b,
	output logic            enable_n,
	output logic            clear,
	output logic            start
);

	cmd_pkg::CMD_STATE_e state;
	cmd_pkg::CMD_STATUS_e status;
	logic is_end;

	assign is_end = (uart_data == cmd_pkg::END_CMD);

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state <= cmd_pkg::WAIT4BYTE;
			status <= cmd_pkg::IDLECMD;
		end else begin
			case (state)
				cmd_pkg::WAIT4BYTE: begin
					if (rx_interrupt)
						state <= cmd_pkg::CHECKSTATUS;
				end
				cmd_pkg::CHECKSTATUS: begin
					state <= cmd_pkg::WAIT4BYTE; // every byte takes exactly one check cycle.
					case (status)
						cmd_pkg::IDLECMD: begin
							if (uart_data == cmd_pkg::START_CMD)
								status <= cmd_pkg::LENGTH; // anything else outside a frame is dropped.
						end
						cmd_pkg::LENGTH: begin
							status <= cmd_pkg::COMMAND; // length byte is not used.
						end
						cmd_pkg::COMMAND: begin
							case (uart_data)
								cmd_pkg::CMD1: status <= cmd_pkg::RCMD1;
								cmd_pkg::CMD2: status <= cmd_pkg::RCMD2;
								cmd_pkg::CMD3: status <= cmd_pkg::RCMD3;
								cmd_pkg::CMD4: status <= cmd_pkg::RCMD4;
								cmd_pkg::CMD5: status <= cmd_pkg::RCMD5;
								default: status <= cmd_pkg::IDLECMD;
							endcase
						end
						cmd_pkg::RCMD1,
						cmd_pkg::RCMD2,
						cmd_pkg::RCMD3,
						cmd_pkg::RCMD4,
						cmd_pkg::RCMD5: begin
							if (is_end)
								status <= cmd_pkg::IDLECMD; // payload runs until the end code.
						end
						default: begin
							status <= cmd_pkg::IDLECMD;
						end
					endcase
				end
				default: begin
					state <= cmd_pkg::WAIT4BYTE;
				end
			endcase
		end
	end

	// Strobes are single pulses in the check cycle, so a frame-end action fires once.
	always_comb begin
		clear_interrupt = 1'b0;
		push_a = 1'b0;
		push_b = 1'b0;
		enable_n = 1'b0;
		clear = 1'b0;
		start = 1'b0;
		if (state == cmd_pkg::CHECKSTATUS) begin
			clear_interrupt = 1'b1; // release the receiver flag.
			case (status)
				cmd_pkg::RCMD1: enable_n = !is_end; // last payload byte wins.
				cmd_pkg::RCMD2: start = is_end;
				cmd_pkg::RCMD3: clear = is_end;
				cmd_pkg::RCMD4: push_a = !is_end;
				cmd_pkg::RCMD5: push_b = !is_end;
				default: begin
				end
			endcase
		end
	end

endmodule

//--- operand_fifo.sv
// Byte queue; a push while full is dropped, a pop while empty does nothing, and clear wins over push.
module operand_fifo #(
	parameter int DEPTH = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            push,
	input  logic            pop,
	input  logic            clear,
	input  uart_pkg::data_t din,
	output uart_pkg::data_t dout,
	output logic            empty,
	output logic            full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	uart_pkg::data_t mem [DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [CNT_W-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign push_ok = push && !full && !clear;
	assign pop_ok = pop && !empty && !clear;
	assign dout = mem[rptr]; // head is valid while not empty.

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else if (clear) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1; // depth need not be a power of two.
			if (pop_ok)
				rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wptr] <= din;
	end

endmodule

//--- dot_engine.sv
// Unsigned dot product of N byte pairs, N capped at DEPTH; starts while busy are ignored.
module dot_engine #(
	parameter int DEPTH = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            enable_n,
	input  uart_pkg::data_t n_data,
	input  logic            start,
	input  uart_pkg::data_t a_data,
	input  uart_pkg::data_t b_data,
	input  logic            a_empty,
	input  logic            b_empty,
	output logic            pop_a,
	output logic            pop_b,
	input  logic            tx_busy,
	output logic            tx_load,
	output uart_pkg::data_t tx_data,
	output logic            busy
);

	localparam int N_W = $clog2(DEPTH + 1);
	localparam int RESULT_BYTES = cmd_pkg::RESULT_W / 8;
	localparam logic [1:0] E_IDLE = 2'd0;
	localparam logic [1:0] E_RUN = 2'd1;
	localparam logic [1:0] E_SEND = 2'd2;

	logic [1:0] state;
	logic [N_W-1:0] n_reg;
	logic [N_W-1:0] remaining;
	logic [1:0] byte_idx;
	logic [cmd_pkg::RESULT_W-1:0] acc;
	logic [15:0] prod;
	logic [3:0] n_low;
	uart_pkg::data_t a_val;
	uart_pkg::data_t b_val;

	assign n_low = n_data[3:0];
	assign a_val = a_empty ? '0 : a_data; // an empty queue reads as zero.
	assign b_val = b_empty ? '0 : b_data;
	assign prod = a_val * b_val;
	assign pop_a = (state == E_RUN);
	assign pop_b = (state == E_RUN);
	assign tx_load = (state == E_SEND) && !tx_busy;
	assign tx_data = acc[(RESULT_BYTES - 1 - int'(byte_idx)) * 8 +: 8]; // msb first.
	assign busy = (state != E_IDLE);

	always_ff @(posedge clk, negedge rst) begin
		if (!rst)
			n_reg <= N_W'(DEPTH);
		else if (enable_n)
			n_reg <= (int'(n_low) > DEPTH) ? N_W'(DEPTH) : N_W'(n_low);
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state <= E_IDLE;
			remaining <= '0;
			byte_idx <= '0;
		end else begin
			case (state)
				E_IDLE: begin
					if (start) begin
						remaining <= n_reg; // later length changes do not affect this run.
						byte_idx <= '0;
						state <= (n_reg == '0) ? E_SEND : E_RUN;
					end
				end
				E_RUN: begin
					remaining <= remaining - 1'b1;
					if (remaining == N_W'(1))
						state <= E_SEND;
				end
				E_SEND: begin
					if (tx_load) begin
						if (byte_idx == 2'(RESULT_BYTES - 1))
							state <= E_IDLE;
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == E_IDLE && start)
			acc <= '0;
		else if (state == E_RUN)
			acc <= acc + cmd_pkg::RESULT_W'(prod);
	end

endmodule

//--- matrix_uart_top.sv
// Serial dot-product coprocessor; host and core must agree on CLKS_PER_BIT, N is capped at DEPTH.
module matrix_uart_top #(
	parameter int CLKS_PER_BIT = 8,
	parameter int DEPTH = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx,
	output logic busy
);

	uart_pkg::data_t uart_data;
	uart_pkg::data_t a_data;
	uart_pkg::data_t b_data;
	uart_pkg::data_t tx_data;
	logic rx_interrupt;
	logic clear_interrupt;
	logic push_a;
	logic push_b;
	logic enable_n;
	logic clear;
	logic start;
	logic pop_a;
	logic pop_b;
	logic a_empty;
	logic b_empty;
	logic tx_load;
	logic tx_busy;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (.clk, .rst, .rx, .clear_interrupt,
		.uart_data, .rx_interrupt);

	cmd_fsm u_cmd_fsm (.clk, .rst, .uart_data, .rx_interrupt, .clear_interrupt,
		.push_a, .push_b, .enable_n, .clear, .start);

	// full stays inside each queue, which drops the extra byte on its own.
	operand_fifo #(.DEPTH(DEPTH)) fifo_a (.clk, .rst, .push(push_a), .pop(pop_a), .clear,
		.din(uart_data), .dout(a_data), .empty(a_empty), .full());

	operand_fifo #(.DEPTH(DEPTH)) fifo_b (.clk, .rst, .push(push_b), .pop(pop_b), .clear,
		.din(uart_data), .dout(b_data), .empty(b_empty), .full());

	dot_engine #(.DEPTH(DEPTH)) u_dot_engine (.clk, .rst, .enable_n, .n_data(uart_data),
		.start, .a_data, .b_data, .a_empty, .b_empty, .pop_a, .pop_b, .tx_busy,
		.tx_load, .tx_data, .busy);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (.clk, .rst, .tx_load, .tx_data,
		.tx, .tx_busy);

endmodule

//--- tb_clock.sv
// Free-running testbench clock starting low; PERIOD is in simulator time units and should be even.
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // equal high and low phases.

endmodule

//--- tb_matrix_uart.sv
// Testbench for the serial coprocessor; BIT_CLKS and DEPTH must match the DUT, payloads avoid 0xEF.
module tb_matrix_uart;

	localparam int BIT_CLKS = 8;
	localparam int DEPTH = 8;
	localparam int GAP = 40; // idle cycles that a frame without a reply is given.
	localparam int REPLY_WAIT = 3 * 10 * BIT_CLKS + GAP;

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	logic busy;

	uart_pkg::data_t bytes[$]; // all frames of the table placed back to back.
	uart_pkg::data_t payload[$]; // scratch payload of the frame being built.
	uart_pkg::data_t replies[$]; // bytes decoded from tx.
	int first[$];
	int count[$];
	bit has_reply[$];
	bit starts[$];
	logic [cmd_pkg::RESULT_W-1:0] exp_val[$];
	uart_pkg::data_t a_vals[DEPTH]; // model of queue A with its head at index 0.
	uart_pkg::data_t b_vals[DEPTH];
	int seed;
	int errors;
	int checks;
	int cycles = 0;
	int limit = 0;
	bit started;

	tb_clock #(.PERIOD(4)) u_tb_clock (.clk);

	matrix_uart_top #(.CLKS_PER_BIT(BIT_CLKS), .DEPTH(DEPTH)) u_matrix_uart_top (.clk, .rst,
		.rx, .tx, .busy);

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
		end
	endtask

	function automatic uart_pkg::data_t rand_byte();
		uart_pkg::data_t b;
		b = uart_pkg::data_t'($random(seed));
		return (b == cmd_pkg::END_CMD) ? 8'h5A : b; // an end code would close the frame early.
	endfunction

	// unsigned sum of N products with N capped at DEPTH and a missing queue entry read as zero.
	function automatic logic [cmd_pkg::RESULT_W-1:0] expected_dot(input int na, input int nb,
		input int n);
		logic [cmd_pkg::RESULT_W-1:0] sum;
		logic [15:0] av;
		logic [15:0] bv;
		int len;
		int i;
		sum = '0;
		len = (n > DEPTH) ? DEPTH : n;
		for (i = 0; i < len; i++) begin
			av = (i < na) ? 16'(a_vals[i]) : 16'd0;
			bv = (i < nb) ? 16'(b_vals[i]) : 16'd0;
			sum = sum + cmd_pkg::RESULT_W'(av * bv);
		end
		return sum;
	endfunction

	task automatic add_frame(input uart_pkg::data_t cmd, input bit reply,
		input logic [cmd_pkg::RESULT_W-1:0] value);
		int base;
		int i;
		base = bytes.size();
		first.push_back(base);
		bytes.push_back(cmd_pkg::START_CMD);
		bytes.push_back(uart_pkg::data_t'(payload.size())); // length byte that the DUT ignores.
		bytes.push_back(cmd);
		for (i = 0; i < payload.size(); i++)
			bytes.push_back(payload[i]);
		bytes.push_back(cmd_pkg::END_CMD);
		count.push_back(bytes.size() - base);
		has_reply.push_back(reply);
		starts.push_back(cmd == cmd_pkg::CMD2);
		exp_val.push_back(value);
		payload.delete();
	endtask

	task automatic one_byte(input uart_pkg::data_t cmd, input uart_pkg::data_t b);
		payload.push_back(b);
		add_frame(cmd, 1'b0, '0);
	endtask

	task automatic load_pair(input int na, input int nb);
		int i;
		for (i = 0; i < na; i++)
			payload.push_back(a_vals[i]);
		add_frame(cmd_pkg::CMD4, 1'b0, '0);
		for (i = 0; i < nb; i++)
			payload.push_back(b_vals[i]);
		add_frame(cmd_pkg::CMD5, 1'b0, '0);
	endtask

	task automatic build_table();
		int i;
		a_vals = '{8'd1, 8'd2, 8'd3, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0};
		b_vals = '{8'd4, 8'd5, 8'd6, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0};
		one_byte(cmd_pkg::CMD1, 8'd3);
		load_pair(3, 3);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(3, 3, 3));
		load_pair(3, 3);
		add_frame(cmd_pkg::CMD3, 1'b0, '0);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(0, 0, 3)); // both queues were cleared.
		payload.push_back(8'h11);
		payload.push_back(8'h22);
		add_frame(8'h09, 1'b0, '0); // unknown command.
		payload.push_back(8'h04);
		payload.push_back(8'h55);
		payload.push_back(8'h66);
		first.push_back(bytes.size()); // loose bytes with no start code.
		for (i = 0; i < payload.size(); i++)
			bytes.push_back(payload[i]);
		count.push_back(payload.size());
		has_reply.push_back(1'b0);
		starts.push_back(1'b0);
		exp_val.push_back('0);
		payload.delete();
		a_vals[0] = 8'd2;
		b_vals[0] = 8'd7;
		one_byte(cmd_pkg::CMD1, 8'd1);
		load_pair(1, 1);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(1, 1, 1));
		a_vals[0] = 8'd3;
		a_vals[1] = 8'd5;
		a_vals[2] = 8'd7;
		b_vals[0] = 8'd9;
		one_byte(cmd_pkg::CMD1, 8'd3);
		load_pair(3, 1);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(3, 1, 3));
		for (i = 0; i < DEPTH; i++) begin
			a_vals[i] = rand_byte();
			b_vals[i] = rand_byte();
		end
		load_pair(DEPTH, DEPTH);
		one_byte(cmd_pkg::CMD1, 8'd15);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(DEPTH, DEPTH, 15));
		for (i = 0; i < DEPTH; i++) begin
			a_vals[i] = rand_byte();
			b_vals[i] = rand_byte();
		end
		load_pair(DEPTH, DEPTH);
		one_byte(cmd_pkg::CMD4, rand_byte()); // queues are full, so both bytes must be lost.
		one_byte(cmd_pkg::CMD5, rand_byte());
		one_byte(cmd_pkg::CMD1, 8'd1);
		add_frame(cmd_pkg::CMD2, 1'b1, expected_dot(DEPTH, DEPTH, 1));
		add_frame(cmd_pkg::CMD3, 1'b0, '0);
	endtask

	// called on a falling edge, returns on the falling edge that ends the stop bit.
	task automatic send_byte(input uart_pkg::data_t b);
		int i;
		rx = 1'b0;
		repeat (BIT_CLKS) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (BIT_CLKS) @(negedge clk);
		end
		rx = 1'b1;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic run_entry(input int e);
		int i;
		int waited;
		logic [cmd_pkg::RESULT_W-1:0] got;
		if (starts[e])
			started = 1'b1; // from here on the engine may become busy.
		replies.delete();
		for (i = 0; i < count[e]; i++)
			send_byte(bytes[first[e] + i]);
		waited = 0;
		if (has_reply[e]) begin
			while (replies.size() < 3 && waited < REPLY_WAIT) begin
				@(negedge clk);
				waited++;
			end
			if (replies.size() < 3) begin
				errors++;
				$display("entry %0d got only %0d of 3 reply bytes on tx", e, replies.size());
			end else begin
				got = {replies[0], replies[1], replies[2]};
				check_value("tx reply", 32'(got), 32'(exp_val[e]));
			end
		end else begin
			repeat (GAP) @(negedge clk);
			check_value("tx reply byte count", 32'(replies.size()), 32'd0);
		end
	endtask

	// decodes tx by sampling each bit on the falling edge nearest its middle.
	always begin
		uart_pkg::data_t b;
		int i;
		@(negedge clk);
		if (rst && tx === 1'b0) begin
			repeat (BIT_CLKS / 2) @(negedge clk);
			for (i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(negedge clk);
				b[i] = tx;
			end
			repeat (BIT_CLKS) @(negedge clk);
			check_value("tx stop bit", 32'(tx), 32'd1);
			replies.push_back(b);
		end
	end

	always @(negedge clk) begin
		if (rst && !started) begin
			check_value("tx", 32'(tx), 32'd1); // line stays idle before the first start.
			check_value("busy", 32'(busy), 32'd0);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout, the run did not end within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		seed = 64374;
		errors = 0;
		checks = 0;
		started = 1'b0;
		rst = 1'b0;
		rx = 1'b1;
		build_table();
		limit = 2 * (bytes.size() * 10 * BIT_CLKS + 40 * first.size());
		repeat (3) @(negedge clk);
		rst = 1'b1;
		repeat (BIT_CLKS) @(negedge clk);
		foreach (first[e])
			run_entry(e);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- vlog.f
uart_pkg.sv
cmd_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_fsm.sv
operand_fifo.sv
dot_engine.sv
matrix_uart_top.sv
tb_clock.sv
tb_matrix_uart.sv

//--- Makefile
TOP := tb_matrix_uart

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

clean:
	rm -rf obj_dir
